//--- Makefile
SIM       := verilator
TOP       := smartnic_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
SIM_FLAGS := --binary --timing --top-module $(TOP) -Mdir $(OBJ_DIR)
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(SIM_FLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/smartnic_tb.sv
`timescale 1ns/1ps

module smartnic_tb import smartnic_pkg::*; ();

    localparam int NUM_PKTS      = 40;
    localparam int DRAIN_TIMEOUT = 40000;
    localparam int APB_TIMEOUT   = 16;

    // One expected egress beat
    typedef struct packed {
        tuser_meta_t         meta;
        logic                last;
        logic [DATA_WID-1:0] data;
    } beat_t;

    logic                    axis_clk;
    logic                    rst_n;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [APB_ADDR_WID-1:0] paddr;
    logic [31:0]             pwdata;
    logic [31:0]             prdata;
    logic                    pready;
    logic                    pslverr;
    logic                    s_tvalid [NUM_PORTS];
    logic                    s_tready [NUM_PORTS];
    logic [DATA_WID-1:0]     s_tdata  [NUM_PORTS];
    port_t                   s_tdest  [NUM_PORTS];
    logic                    s_tlast  [NUM_PORTS];
    logic                    m_tvalid [NUM_PORTS];
    logic                    m_tready [NUM_PORTS];
    logic [DATA_WID-1:0]     m_tdata  [NUM_PORTS];
    tuser_meta_t             m_tuser  [NUM_PORTS];
    logic                    m_tlast  [NUM_PORTS];

    // Reference model state
    qid_t        qbase_model [NUM_QBASE];
    beat_t       exp_q [NUM_PORTS*NUM_PORTS][$];
    int          owner      [NUM_PORTS];
    int          beats_left [NUM_PORTS];
    int          beat_no    [NUM_PORTS];
    int          sent       [NUM_PORTS];
    logic [31:0] lfsr = 32'h2bc0_ace1;

    smartnic_lite #(.DATA_WID(DATA_WID)) smartnic_lite_inst (.*);

    initial axis_clk = 1'b0;
    always #20 axis_clk = ~axis_clk;

    // ==================================================================
    // Random numbers and reference rules
    // ==================================================================

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int b = 0; b < n; b++) begin
            r[b] = lfsr[0];
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'hd000_0001 : 32'h0);
        end
        return r;
    endfunction

    function automatic int exp_egress(input logic [3:0] code);
        if (code >= 4'd2 && code <= 4'd5) return 2;
        if (code >= 4'd6 && code <= 4'd9) return 3;
        if (code == 4'd1) return 1;
        return 0;
    endfunction

    // Host egress carries the base queue of the function
    function automatic tuser_meta_t exp_meta(input int egr, input logic [3:0] code);
        tuser_meta_t m;
        m = '0;
        if (egr >= 2) begin
            m.rss_enable  = 1'b1;
            m.rss_entropy = qbase_model[int'(code) - 2];
        end
        return m;
    endfunction

    // ==================================================================
    // Compare tasks
    // ==================================================================

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input logic [DATA_WID-1:0] got,
                              input logic [DATA_WID-1:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_meta(input string name, input tuser_meta_t got,
                              input tuser_meta_t exp);
        if (got !== exp) begin
            fail_now($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_last(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                               $time, name, got, exp));
        end
    endtask

    // ==================================================================
    // Reset and APB
    // ==================================================================

    task automatic check_idle(input bit ingress_too);
        for (int e = 0; e < NUM_PORTS; e++) begin
            check_flag($sformatf("m_tvalid[%0d]", e), m_tvalid[e], 1'b0);
        end
        // Ingress ready stays low through the cycle that ends reset
        if (ingress_too) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                check_flag($sformatf("s_tready[%0d]", i), s_tready[i], 1'b0);
            end
        end
    endtask

    task automatic apply_reset();
        for (int c = 0; c < 15; c++) begin
            @(negedge axis_clk);
            check_idle(1'b1);
        end
        @(posedge axis_clk);
        #2;
        rst_n = 1'b1;
        // Last reset cycle, then the first cycle out of reset
        @(negedge axis_clk);
        check_idle(1'b1);
        @(negedge axis_clk);
        check_idle(1'b0);
    endtask

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int waited;
        @(posedge axis_clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge axis_clk);
        #2;
        penable = 1'b1;
        waited  = 0;
        @(negedge axis_clk);
        while (!pready) begin
            waited++;
            if (waited > APB_TIMEOUT) begin
                fail_now("APB transfer never saw pready");
            end
            @(negedge axis_clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge axis_clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic check_readback();
        logic [31:0] rdata;
        logic        err;
        for (int r = 0; r < NUM_QBASE; r++) begin
            apb_xfer(1'b0, 8'(4 * r), 32'h0, rdata, err);
            check_flag($sformatf("pslverr rd 0x%02h", 4 * r), err, 1'b0);
            check_word($sformatf("prdata 0x%02h", 4 * r), rdata, 32'(qbase_model[r]));
        end
    endtask

    task automatic test_registers();
        logic [31:0] wval;
        logic [31:0] rdata;
        logic        err;
        for (int r = 0; r < NUM_QBASE; r++) begin
            wval = rand_bits(32);
            apb_xfer(1'b1, 8'(4 * r), wval, rdata, err);
            check_flag($sformatf("pslverr wr 0x%02h", 4 * r), err, 1'b0);
            qbase_model[r] = wval[11:0];
        end
        check_readback();
        // Out of range and unaligned offsets
        apb_xfer(1'b1, 8'h20, 32'hffff_ffff, rdata, err);
        check_flag("pslverr wr 0x20", err, 1'b1);
        apb_xfer(1'b1, 8'h05, 32'hffff_ffff, rdata, err);
        check_flag("pslverr wr 0x05", err, 1'b1);
        apb_xfer(1'b0, 8'h24, 32'h0, rdata, err);
        check_flag("pslverr rd 0x24", err, 1'b1);
        check_word("prdata 0x24", rdata, 32'h0);
        apb_xfer(1'b0, 8'h06, 32'h0, rdata, err);
        check_flag("pslverr rd 0x06", err, 1'b1);
        check_word("prdata 0x06", rdata, 32'h0);
        check_readback();
    endtask

    // ==================================================================
    // Packet traffic
    // ==================================================================

    task automatic record_ingress(input int i);
        beat_t b;
        int    e;
        e      = exp_egress(s_tdest[i]);
        b.meta = exp_meta(e, s_tdest[i]);
        b.last = s_tlast[i];
        b.data = s_tdata[i];
        exp_q[e * NUM_PORTS + i].push_back(b);
    endtask

    task automatic check_egress(input int e);
        beat_t exp;
        int    src;
        int    hits;
        src = owner[e];
        if (src < 0) begin
            // A new packet must match one ingress head
            hits = 0;
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (exp_q[e * NUM_PORTS + i].size() > 0) begin
                    exp = exp_q[e * NUM_PORTS + i][0];
                    if (exp.data === m_tdata[e]) begin
                        hits++;
                        src = i;
                    end
                end
            end
            if (hits != 1) begin
                fail_now($sformatf("Egress %0d started a packet at %0t that matches %0d heads",
                                   e, $time, hits));
            end
        end else if (exp_q[e * NUM_PORTS + src].size() == 0) begin
            fail_now($sformatf("Egress %0d sent an extra beat at %0t", e, $time));
        end
        exp = exp_q[e * NUM_PORTS + src].pop_front();
        check_data($sformatf("m_tdata[%0d]", e), m_tdata[e], exp.data);
        check_meta($sformatf("m_tuser[%0d]", e), m_tuser[e], exp.meta);
        check_last($sformatf("m_tlast[%0d]", e), m_tlast[e], exp.last);
        owner[e] = exp.last ? -1 : src;
    endtask

    task automatic drive_ingress(input int i, input logic fired);
        if (fired) begin
            s_tvalid[i] = 1'b0;
            beats_left[i]--;
            if (beats_left[i] == 0) begin
                sent[i]++;
            end
        end
        if (!s_tvalid[i]) begin
            if (beats_left[i] == 0 && sent[i] < NUM_PKTS) begin
                beats_left[i] = int'(rand_bits(3)) + 1;
                beat_no[i]    = 0;
                s_tdest[i]    = port_t'(4'(rand_bits(4)));
            end
            // Idle gaps between beats
            if (beats_left[i] > 0 && rand_bits(2) != 32'd0) begin
                s_tvalid[i] = 1'b1;
                s_tlast[i]  = (beats_left[i] == 1);
                s_tdata[i]  = {2'(i), 14'(sent[i]), 16'(beat_no[i]), rand_bits(32)};
                beat_no[i]++;
            end
        end
    endtask

    task automatic run_traffic();
        logic fired [NUM_PORTS];
        int   cycles;
        bit   done;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge axis_clk);
            for (int e = 0; e < NUM_PORTS; e++) begin
                if (m_tvalid[e] && m_tready[e]) begin
                    check_egress(e);
                end
            end
            for (int i = 0; i < NUM_PORTS; i++) begin
                fired[i] = s_tvalid[i] && s_tready[i];
                if (fired[i]) begin
                    record_ingress(i);
                end
            end
            @(posedge axis_clk);
            #2;
            for (int i = 0; i < NUM_PORTS; i++) begin
                drive_ingress(i, fired[i]);
            end
            for (int e = 0; e < NUM_PORTS; e++) begin
                m_tready[e] = (rand_bits(2) != 32'd0);
            end
            done = 1'b1;
            for (int k = 0; k < NUM_PORTS * NUM_PORTS; k++) begin
                if (exp_q[k].size() != 0 || sent[k % NUM_PORTS] < NUM_PKTS) begin
                    done = 1'b0;
                end
            end
            cycles++;
            if (cycles > DRAIN_TIMEOUT) begin
                fail_now("Packet traffic did not drain before the timeout");
            end
        end
    endtask

    // Nothing may leave once every model queue is empty
    task automatic check_drained();
        for (int c = 0; c < 8; c++) begin
            @(negedge axis_clk);
            check_idle(1'b0);
        end
    endtask

    initial begin
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            s_tvalid[i]   = 1'b0;
            s_tdata[i]    = '0;
            s_tdest[i]    = CMAC0;
            s_tlast[i]    = 1'b0;
            m_tready[i]   = 1'b0;
            owner[i]      = -1;
            beats_left[i] = 0;
            beat_no[i]    = 0;
            sent[i]       = 0;
        end
        apply_reset();
        test_registers();
        run_traffic();
        check_drained();
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- src.f
src/smartnic_pkg.sv
src/axis_slice.sv
src/hash2qid_regs.sv
src/egr_port_arbiter.sv
src/egr_meta_stamp.sv
src/smartnic_lite.sv
sim/smartnic_tb.sv

//--- src/axis_slice.sv
`timescale 1ns/1ps

module axis_slice #(
    parameter type PAYLOAD_T = logic [63:0]
) (
    input  logic     axis_clk,
    input  logic     rst_n,

    input  logic     in_valid,
    output logic     in_ready,
    input  PAYLOAD_T in_payload,

    output logic     out_valid,
    input  logic     out_ready,
    output PAYLOAD_T out_payload
);

    logic     skid_valid;
    logic     skid_nxt;
    PAYLOAD_T skid_payload;
    logic     in_fire;
    logic     out_free;

    assign in_fire  = in_valid & in_ready;
    assign out_free = out_ready | ~out_valid;

    // Skid entry fills only when a beat arrives while the output stalls
    assign skid_nxt = out_free ? 1'b0 : (skid_valid | in_fire);

    always_ff @(posedge axis_clk) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            skid_valid <= skid_nxt;
            in_ready   <= ~skid_nxt;
            if (out_free) begin
                out_valid <= skid_valid | in_fire;
            end
        end
    end

    // Payload path
    always_ff @(posedge axis_clk) begin
        if (out_free) begin
            out_payload <= skid_valid ? skid_payload : in_payload;
        end
        if (!out_free && in_fire) begin
            skid_payload <= in_payload;
        end
    end

endmodule

//--- src/egr_meta_stamp.sv
`timescale 1ns/1ps

module egr_meta_stamp import smartnic_pkg::*; #(
    parameter egr_idx_t EGR_IDX = 2'd0
) (
    input  port_t       dest,
    input  qid_t        qbase [NUM_QBASE],
    output tuser_meta_t meta
);

    localparam int IDX_WID = $clog2(NUM_QBASE);

    // Egress 2 and 3 lead to the host functions
    localparam bit TO_HOST = (EGR_IDX == 2'd2) || (EGR_IDX == 2'd3);

    logic [$bits(port_t)-1:0] code_off;
    logic [IDX_WID-1:0]       qidx;

    // Register index is the code minus PF0
    assign code_off = dest - PF0;
    assign qidx     = code_off[IDX_WID-1:0];

    always_comb begin
        meta = '0;
        if (TO_HOST) begin
            meta.rss_enable  = 1'b1;
            meta.rss_entropy = qbase[qidx];
        end
    end

endmodule

//--- src/egr_port_arbiter.sv
`timescale 1ns/1ps

module egr_port_arbiter import smartnic_pkg::*; #(
    parameter int       DATA_WID = smartnic_pkg::DATA_WID,
    parameter egr_idx_t EGR_IDX  = 2'd0
) (
    input  logic                axis_clk,
    input  logic                rst_n,

    input  logic                in_valid [NUM_PORTS],
    input  logic [DATA_WID-1:0] in_data  [NUM_PORTS],
    input  port_t               in_dest  [NUM_PORTS],
    input  logic                in_last  [NUM_PORTS],
    output logic                in_ready [NUM_PORTS],

    output logic                out_valid,
    input  logic                out_ready,
    output logic [DATA_WID-1:0] out_data,
    output port_t               out_dest,
    output logic                out_last
);

    localparam int IDX_WID = $clog2(NUM_PORTS);

    // Destination code to egress index
    function automatic egr_idx_t route(input port_t dest);
        case (dest)
            PF0, PF0_VF0, PF0_VF1, PF0_VF2: route = 2'd2;
            PF1, PF1_VF0, PF1_VF1, PF1_VF2: route = 2'd3;
            CMAC1:                          route = 2'd1;
            default:                        route = 2'd0;
        endcase
    endfunction

    logic [NUM_PORTS-1:0] req;
    logic [IDX_WID-1:0]   grant;
    logic                 locked;
    logic [IDX_WID-1:0]   sel;
    logic                 sel_valid;
    logic                 out_free;
    logic                 take;

    // ===================================================================
    // Request and grant
    // ===================================================================

    // Only beats addressed to this egress are requests
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            req[i] = in_valid[i] && (route(in_dest[i]) == EGR_IDX);
        end
    end

    // Round robin, searching from the ingress after the last grant
    always_comb begin : rr_pick
        logic [IDX_WID-1:0] idx;
        idx = grant;
        sel = grant;
        if (!locked) begin
            for (int k = NUM_PORTS; k >= 1; k--) begin
                idx = grant + IDX_WID'(k);
                if (req[idx]) begin
                    sel = idx;
                end
            end
        end
    end

    // Mid-packet the grant stays on the owner
    assign sel_valid = locked ? req[grant] : |req;
    assign out_free  = out_ready | ~out_valid;
    assign take      = out_free & sel_valid;

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            in_ready[i] = take && (sel == IDX_WID'(i));
        end
    end

    // ===================================================================
    // Output stage
    // ===================================================================

    always_ff @(posedge axis_clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            locked    <= 1'b0;
            // First search starts at ingress 0
            grant     <= '1;
        end else if (take) begin
            out_valid <= 1'b1;
            grant     <= sel;
            locked    <= ~in_last[sel];
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (take) begin
            out_data <= in_data[sel];
            out_dest <= in_dest[sel];
            out_last <= in_last[sel];
        end
    end

endmodule

//--- src/hash2qid_regs.sv
`timescale 1ns/1ps

module hash2qid_regs import smartnic_pkg::*; (
    input  logic                    axis_clk,
    input  logic                    rst_n,

    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [APB_ADDR_WID-1:0] paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,

    output qid_t                    qbase [NUM_QBASE]
);

    localparam int IDX_WID = $clog2(NUM_QBASE);
    localparam int QID_WID = $bits(qid_t);

    // ===================================================================
    // Address decode
    // ===================================================================

    logic               access;
    logic               addr_ok;
    logic [IDX_WID-1:0] reg_idx;
    logic               wr_en;

    // Word offsets 0x00 to 0x1C, word aligned only
    assign reg_idx = paddr[IDX_WID+1:2];
    assign addr_ok = (paddr[1:0] == 2'b00) &&
                     (paddr[APB_ADDR_WID-1:IDX_WID+2] == '0);

    // Access phase of a transfer
    assign access = psel & penable;
    assign wr_en  = access & pwrite & addr_ok;

    // No wait states
    assign pready = 1'b1;

    assign pslverr = access & ~addr_ok;

    // ===================================================================
    // Base queue registers
    // ===================================================================

    // Order: PF0, PF0_VF0..VF2, PF1, PF1_VF0..VF2
    always_ff @(posedge axis_clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_QBASE; i++) begin
                qbase[i] <= '0;
            end
        end else if (wr_en) begin
            qbase[reg_idx] <= pwdata[QID_WID-1:0];
        end
    end

    // Read data, upper bits zero
    always_comb begin
        prdata = '0;
        if (psel && !pwrite && addr_ok) begin
            prdata = 32'(qbase[reg_idx]);
        end
    end

endmodule

//--- src/smartnic_lite.sv
`timescale 1ns/1ps

module smartnic_lite import smartnic_pkg::*; #(
    parameter int DATA_WID = smartnic_pkg::DATA_WID
) (
    input  logic                    axis_clk,
    input  logic                    rst_n,

    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [APB_ADDR_WID-1:0] paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,

    input  logic                    s_tvalid [NUM_PORTS],
    output logic                    s_tready [NUM_PORTS],
    input  logic [DATA_WID-1:0]     s_tdata  [NUM_PORTS],
    input  port_t                   s_tdest  [NUM_PORTS],
    input  logic                    s_tlast  [NUM_PORTS],

    output logic                    m_tvalid [NUM_PORTS],
    input  logic                    m_tready [NUM_PORTS],
    output logic [DATA_WID-1:0]     m_tdata  [NUM_PORTS],
    output tuser_meta_t             m_tuser  [NUM_PORTS],
    output logic                    m_tlast  [NUM_PORTS]
);

    typedef struct packed {
        logic [DATA_WID-1:0] data;
        port_t               dest;
        logic                last;
    } igr_payload_t;

    typedef struct packed {
        logic [DATA_WID-1:0] data;
        tuser_meta_t         user;
        logic                last;
    } egr_payload_t;

    igr_payload_t        igr_in    [NUM_PORTS];
    igr_payload_t        igr_out   [NUM_PORTS];
    logic                igr_valid [NUM_PORTS];
    logic                igr_ready [NUM_PORTS];
    logic [DATA_WID-1:0] igr_data  [NUM_PORTS];
    port_t               igr_dest  [NUM_PORTS];
    logic                igr_last  [NUM_PORTS];

    // Indexed [egress][ingress]
    logic                arb_accept [NUM_PORTS][NUM_PORTS];

    logic                arb_valid [NUM_PORTS];
    logic                arb_ready [NUM_PORTS];
    logic [DATA_WID-1:0] arb_data  [NUM_PORTS];
    port_t               arb_dest  [NUM_PORTS];
    logic                arb_last  [NUM_PORTS];
    tuser_meta_t         arb_meta  [NUM_PORTS];

    egr_payload_t        egr_in  [NUM_PORTS];
    egr_payload_t        egr_out [NUM_PORTS];

    qid_t                qbase [NUM_QBASE];

    // ===================================================================
    // Ingress slices
    // ===================================================================

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_igr
        assign igr_in[i] = '{data: s_tdata[i], dest: s_tdest[i], last: s_tlast[i]};

        axis_slice #(.PAYLOAD_T(igr_payload_t)) igr_slice_inst (
            .axis_clk    (axis_clk),
            .rst_n       (rst_n),
            .in_valid    (s_tvalid[i]),
            .in_ready    (s_tready[i]),
            .in_payload  (igr_in[i]),
            .out_valid   (igr_valid[i]),
            .out_ready   (igr_ready[i]),
            .out_payload (igr_out[i])
        );

        assign igr_data[i] = igr_out[i].data;
        assign igr_dest[i] = igr_out[i].dest;
        assign igr_last[i] = igr_out[i].last;
    end

    // At most one arbiter accepts a given beat
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            igr_ready[i] = 1'b0;
            for (int j = 0; j < NUM_PORTS; j++) begin
                igr_ready[i] = igr_ready[i] | arb_accept[j][i];
            end
        end
    end

    // ===================================================================
    // Egress: arbiter, metadata, slice
    // ===================================================================

    for (genvar j = 0; j < NUM_PORTS; j++) begin : g_egr
        egr_port_arbiter #(
            .DATA_WID (DATA_WID),
            .EGR_IDX  (egr_idx_t'(j))
        ) arb_inst (
            .axis_clk  (axis_clk),
            .rst_n     (rst_n),
            .in_valid  (igr_valid),
            .in_data   (igr_data),
            .in_dest   (igr_dest),
            .in_last   (igr_last),
            .in_ready  (arb_accept[j]),
            .out_valid (arb_valid[j]),
            .out_ready (arb_ready[j]),
            .out_data  (arb_data[j]),
            .out_dest  (arb_dest[j]),
            .out_last  (arb_last[j])
        );

        egr_meta_stamp #(.EGR_IDX(egr_idx_t'(j))) stamp_inst (
            .dest  (arb_dest[j]),
            .qbase (qbase),
            .meta  (arb_meta[j])
        );

        assign egr_in[j] = '{data: arb_data[j], user: arb_meta[j], last: arb_last[j]};

        axis_slice #(.PAYLOAD_T(egr_payload_t)) egr_slice_inst (
            .axis_clk    (axis_clk),
            .rst_n       (rst_n),
            .in_valid    (arb_valid[j]),
            .in_ready    (arb_ready[j]),
            .in_payload  (egr_in[j]),
            .out_valid   (m_tvalid[j]),
            .out_ready   (m_tready[j]),
            .out_payload (egr_out[j])
        );

        assign m_tdata[j] = egr_out[j].data;
        assign m_tuser[j] = egr_out[j].user;
        assign m_tlast[j] = egr_out[j].last;
    end

    // Base queue ids for the host functions
    hash2qid_regs hash2qid_regs_inst (
        .axis_clk (axis_clk),
        .rst_n    (rst_n),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .qbase    (qbase)
    );

endmodule

//--- src/smartnic_pkg.sv
package smartnic_pkg;

    // ===================================================================
    // Port codes and sizes
    // ===================================================================

    // Destination code carried in tdest; codes 10 to 15 route as CMAC0
    typedef enum logic [3:0] {
        CMAC0   = 4'd0,
        CMAC1   = 4'd1,
        PF0     = 4'd2,
        PF0_VF0 = 4'd3,
        PF0_VF1 = 4'd4,
        PF0_VF2 = 4'd5,
        PF1     = 4'd6,
        PF1_VF0 = 4'd7,
        PF1_VF1 = 4'd8,
        PF1_VF2 = 4'd9
    } port_t;

    localparam int NUM_PORTS = 4;

    // Egress index: 0 CMAC0, 1 CMAC1, 2 PF0, 3 PF1
    typedef logic [1:0] egr_idx_t;

    // One base queue per PF/VF
    localparam int NUM_QBASE = 8;

    typedef logic [11:0] qid_t;

    // ===================================================================
    // Egress tuser
    // ===================================================================

    // All zero on CMAC egress, which reads as error clear
    typedef struct packed {
        logic rss_enable;
        qid_t rss_entropy;
    } tuser_meta_t;

    localparam int DATA_WID     = 64;
    localparam int APB_ADDR_WID = 8;

endpackage
